// ==== include/rv_cfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Datapath width
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_NREGS 32

// Data memory depth in words
`define RV_DMEM_WORDS 16

`endif

// ==== src/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // Major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // funct3 codes for ALU ops and word access
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_LW  = 3'b010;

    localparam logic [6:0] F7_SUB = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // One instruction word, viewed per format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
    } rv_instr_u;

endpackage

// ==== src/rv_pipe_pkg.sv ====
package rv_pipe_pkg;

    // Operation selected by decode for the execute ALU
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_PASSB
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    // Decode FSM
    typedef enum logic {
        GET_INSTR,
        DECODE_INSTR
    } dec_state_e;

endpackage

// ==== src/rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_decode (
    input  logic                              clk,
    input  logic                              resetn_i,
    input  logic                              instr_give_i,
    output logic                              instr_get_o,
    input  rv_isa_pkg::rv_instr_u             instr_i,
    output logic                              inv_instr_o,
    input  logic                              ex_get_i,
    output logic                              ex_give_o,
    output rv_pipe_pkg::alu_op_e              ex_alu_op_o,
    output rv_pipe_pkg::mem_op_e              ex_mem_op_o,
    output logic [$clog2(`RV_NREGS)-1:0]      ex_rd_o,
    output logic                              ex_wen_o,
    output logic [`RV_XLEN-1:0]               ex_a_o,
    output logic [`RV_XLEN-1:0]               ex_b_o,
    output logic [`RV_XLEN-1:0]               ex_store_d_o,
    output logic [$clog2(`RV_NREGS)-1:0]      rs1_addr_o,
    output logic [$clog2(`RV_NREGS)-1:0]      rs2_addr_o,
    input  logic [`RV_XLEN-1:0]               rs1_d_i,
    input  logic [`RV_XLEN-1:0]               rs2_d_i,
    input  logic                              reg_access_i,
    output logic                              claim_o,
    output logic [$clog2(`RV_NREGS)-1:0]      claim_rd_o
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    dec_state_e              state_q;
    dec_state_e              state_d;
    rv_instr_u               instr_q;
    logic                    instr_valid;
    logic                    issue;
    logic                    b_is_imm;
    logic [`RV_XLEN-1:0]     imm;
    logic                    f3_ok;
    alu_op_e                 f3_op;

    always_ff @(posedge clk) begin
        if (resetn_i) begin
            state_q <= GET_INSTR;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == GET_INSTR && instr_give_i) begin
            instr_q <= instr_i;
        end
    end

    // ALU op shared by OP and OP-IMM
    always_comb begin
        f3_ok = 1'b1;
        f3_op = ALU_ADD;
        case (instr_q.r_fmt.funct3)
            F3_ADD:  f3_op = ALU_ADD;
            F3_SLT:  f3_op = ALU_SLT;
            F3_XOR:  f3_op = ALU_XOR;
            F3_OR:   f3_op = ALU_OR;
            F3_AND:  f3_op = ALU_AND;
            default: f3_ok = 1'b0;
        endcase
    end

    always_comb begin
        instr_valid = 1'b0;
        ex_alu_op_o = ALU_ADD;
        ex_mem_op_o = MEM_NONE;
        ex_wen_o    = 1'b1;
        ex_rd_o     = instr_q.r_fmt.rd;
        rs1_addr_o  = '0;
        rs2_addr_o  = '0;
        b_is_imm    = 1'b1;
        imm         = '0;
        case (instr_q.r_fmt.opcode)
            OPC_LUI: begin
                // rs1 stays x0, so operand a reads as zero
                instr_valid = 1'b1;
                ex_alu_op_o = ALU_PASSB;
                imm = {instr_q.i_fmt.imm12, instr_q.i_fmt.rs1, instr_q.i_fmt.funct3, 12'b0};
            end
            OPC_OP_IMM: begin
                instr_valid = f3_ok;
                ex_alu_op_o = f3_op;
                rs1_addr_o  = instr_q.i_fmt.rs1;
                imm = {{(`RV_XLEN-12){instr_q.i_fmt.imm12[11]}}, instr_q.i_fmt.imm12};
            end
            OPC_OP: begin
                rs1_addr_o = instr_q.r_fmt.rs1;
                rs2_addr_o = instr_q.r_fmt.rs2;
                b_is_imm   = 1'b0;
                if (instr_q.r_fmt.funct7 == 7'b0) begin
                    instr_valid = f3_ok;
                    ex_alu_op_o = f3_op;
                end else if (instr_q.r_fmt.funct7 == F7_SUB &&
                             instr_q.r_fmt.funct3 == F3_ADD) begin
                    instr_valid = 1'b1;
                    ex_alu_op_o = ALU_SUB;
                end
            end
            OPC_LOAD: begin
                instr_valid = (instr_q.i_fmt.funct3 == F3_LW);
                ex_mem_op_o = MEM_LOAD;
                rs1_addr_o  = instr_q.i_fmt.rs1;
                imm = {{(`RV_XLEN-12){instr_q.i_fmt.imm12[11]}}, instr_q.i_fmt.imm12};
            end
            OPC_STORE: begin
                instr_valid = (instr_q.s_fmt.funct3 == F3_LW);
                ex_mem_op_o = MEM_STORE;
                ex_wen_o    = 1'b0;
                ex_rd_o     = '0;
                rs1_addr_o  = instr_q.s_fmt.rs1;
                rs2_addr_o  = instr_q.s_fmt.rs2;
                imm = {{(`RV_XLEN-12){instr_q.s_fmt.imm_hi[6]}},
                       instr_q.s_fmt.imm_hi, instr_q.s_fmt.imm_lo};
            end
            default: begin
                instr_valid = 1'b0;
            end
        endcase
    end

    // Hand over only when execute is free and no source is pending
    assign issue = (state_q == DECODE_INSTR) && instr_valid && ex_get_i && reg_access_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            GET_INSTR: begin
                if (instr_give_i) begin
                    state_d = DECODE_INSTR;
                end
            end
            DECODE_INSTR: begin
                if (!instr_valid || issue) begin
                    state_d = GET_INSTR;
                end
            end
            default: state_d = GET_INSTR;
        endcase
    end

    assign instr_get_o  = (state_q == GET_INSTR);
    assign inv_instr_o  = (state_q == DECODE_INSTR) && !instr_valid;
    assign ex_give_o    = issue;
    assign ex_a_o       = rs1_d_i;
    assign ex_b_o       = b_is_imm ? imm : rs2_d_i;
    assign ex_store_d_o = rs2_d_i;

    // Mark destination busy as the instruction leaves decode
    assign claim_o    = issue && ex_wen_o && (ex_rd_o != '0);
    assign claim_rd_o = ex_rd_o;

endmodule

// ==== src/rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_regfile (
    input  logic                              clk,
    input  logic                              resetn_i,
    input  logic [$clog2(`RV_NREGS)-1:0]      rs1_addr_i,
    input  logic [$clog2(`RV_NREGS)-1:0]      rs2_addr_i,
    output logic [`RV_XLEN-1:0]               rs1_d_o,
    output logic [`RV_XLEN-1:0]               rs2_d_o,
    output logic                              reg_access_o,
    input  logic                              claim_i,
    input  logic [$clog2(`RV_NREGS)-1:0]      claim_rd_i,
    input  logic                              wb_en_i,
    input  logic [$clog2(`RV_NREGS)-1:0]      wb_rd_i,
    input  logic [`RV_XLEN-1:0]               wb_d_i
);

    logic [`RV_XLEN-1:0]   regs [`RV_NREGS];
    logic [`RV_NREGS-1:0]  busy_q;

    // x0 is never written, so it stays at its reset value of zero
    always_ff @(posedge clk) begin
        if (resetn_i) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en_i && wb_rd_i != '0) begin
            regs[wb_rd_i] <= wb_d_i;
        end
    end

    // Claim is applied last so it wins over a same-cycle writeback
    always_ff @(posedge clk) begin
        if (resetn_i) begin
            busy_q <= '0;
        end else begin
            if (wb_en_i) begin
                busy_q[wb_rd_i] <= 1'b0;
            end
            if (claim_i && claim_rd_i != '0) begin
                busy_q[claim_rd_i] <= 1'b1;
            end
        end
    end

    assign rs1_d_o = regs[rs1_addr_i];
    assign rs2_d_o = regs[rs2_addr_i];

    assign reg_access_o = !busy_q[rs1_addr_i] && !busy_q[rs2_addr_i];

endmodule

// ==== src/rv_execute.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_execute (
    input  logic                              clk,
    input  logic                              resetn_i,
    input  logic                              ex_give_i,
    output logic                              ex_get_o,
    input  rv_pipe_pkg::alu_op_e              ex_alu_op_i,
    input  rv_pipe_pkg::mem_op_e              ex_mem_op_i,
    input  logic [$clog2(`RV_NREGS)-1:0]      ex_rd_i,
    input  logic                              ex_wen_i,
    input  logic [`RV_XLEN-1:0]               ex_a_i,
    input  logic [`RV_XLEN-1:0]               ex_b_i,
    input  logic [`RV_XLEN-1:0]               ex_store_d_i,
    output logic                              wb_en_o,
    output logic [$clog2(`RV_NREGS)-1:0]      wb_rd_o,
    output logic [`RV_XLEN-1:0]               wb_d_o,
    output logic                              wb_valid_o,
    output logic [`RV_XLEN-1:0]               wb_data_o,
    input  logic                              wb_ready_i
);
    import rv_pipe_pkg::*;

    localparam int dmem_aw = $clog2(`RV_DMEM_WORDS);

    logic [`RV_XLEN-1:0]                dmem [`RV_DMEM_WORDS];
    logic [`RV_XLEN-1:0]                alu_res;
    logic [dmem_aw-1:0]                 dmem_idx;
    logic                               ex_xfer;
    logic                               wb_valid_q;
    logic [$clog2(`RV_NREGS)-1:0]       wb_rd_q;
    logic [`RV_XLEN-1:0]                wb_data_q;

    always_comb begin
        case (ex_alu_op_i)
            ALU_ADD:   alu_res = ex_a_i + ex_b_i;
            ALU_SUB:   alu_res = ex_a_i - ex_b_i;
            ALU_SLT:   alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(ex_a_i) < $signed(ex_b_i)};
            ALU_XOR:   alu_res = ex_a_i ^ ex_b_i;
            ALU_OR:    alu_res = ex_a_i | ex_b_i;
            ALU_AND:   alu_res = ex_a_i & ex_b_i;
            ALU_PASSB: alu_res = ex_b_i;
            default:   alu_res = '0;
        endcase
    end

    // Word index from the byte address
    assign dmem_idx = alu_res[2 +: dmem_aw];

    // Accept when empty or when the held result leaves this cycle
    assign ex_get_o = !wb_valid_q || wb_ready_i;
    assign ex_xfer  = ex_give_i && ex_get_o;

    always_ff @(posedge clk) begin
        if (resetn_i) begin
            for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_xfer && ex_mem_op_i == MEM_STORE) begin
            dmem[dmem_idx] <= ex_store_d_i;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn_i) begin
            wb_valid_q <= 1'b0;
        end else if (ex_xfer && ex_wen_i) begin
            wb_valid_q <= 1'b1;
        end else if (wb_ready_i) begin
            wb_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_xfer && ex_wen_i) begin
            wb_rd_q   <= ex_rd_i;
            wb_data_q <= (ex_mem_op_i == MEM_LOAD) ? dmem[dmem_idx] : alu_res;
        end
    end

    // Register file sees the result only once the outside takes it
    assign wb_en_o    = wb_valid_q && wb_ready_i;
    assign wb_rd_o    = wb_rd_q;
    assign wb_d_o     = wb_data_q;
    assign wb_valid_o = wb_valid_q;
    assign wb_data_o  = wb_data_q;

endmodule

// ==== src/rv_core_top.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core_top (
    input  logic                              clk,
    input  logic                              resetn_i,
    input  logic                              instr_give_i,
    output logic                              instr_get_o,
    input  logic [31:0]                       instr_i,
    output logic                              inv_instr_o,
    output logic                              wb_valid_o,
    output logic [$clog2(`RV_NREGS)-1:0]      wb_rd_o,
    output logic [`RV_XLEN-1:0]               wb_data_o,
    input  logic                              wb_ready_i
);
    import rv_pipe_pkg::*;

    logic                               ex_give;
    logic                               ex_get;
    alu_op_e                            ex_alu_op;
    mem_op_e                            ex_mem_op;
    logic [$clog2(`RV_NREGS)-1:0]       ex_rd;
    logic                               ex_wen;
    logic [`RV_XLEN-1:0]                ex_a;
    logic [`RV_XLEN-1:0]                ex_b;
    logic [`RV_XLEN-1:0]                ex_store_d;
    logic [$clog2(`RV_NREGS)-1:0]       rs1_addr;
    logic [$clog2(`RV_NREGS)-1:0]       rs2_addr;
    logic [`RV_XLEN-1:0]                rs1_d;
    logic [`RV_XLEN-1:0]                rs2_d;
    logic                               reg_access;
    logic                               claim;
    logic [$clog2(`RV_NREGS)-1:0]       claim_rd;
    logic                               wb_en;
    logic [`RV_XLEN-1:0]                wb_d;

    rv_decode rv_decode_i (
        .clk          (clk),
        .resetn_i     (resetn_i),
        .instr_give_i (instr_give_i),
        .instr_get_o  (instr_get_o),
        .instr_i      (instr_i),
        .inv_instr_o  (inv_instr_o),
        .ex_get_i     (ex_get),
        .ex_give_o    (ex_give),
        .ex_alu_op_o  (ex_alu_op),
        .ex_mem_op_o  (ex_mem_op),
        .ex_rd_o      (ex_rd),
        .ex_wen_o     (ex_wen),
        .ex_a_o       (ex_a),
        .ex_b_o       (ex_b),
        .ex_store_d_o (ex_store_d),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rs1_d_i      (rs1_d),
        .rs2_d_i      (rs2_d),
        .reg_access_i (reg_access),
        .claim_o      (claim),
        .claim_rd_o   (claim_rd)
    );

    rv_regfile rv_regfile_i (
        .clk          (clk),
        .resetn_i     (resetn_i),
        .rs1_addr_i   (rs1_addr),
        .rs2_addr_i   (rs2_addr),
        .rs1_d_o      (rs1_d),
        .rs2_d_o      (rs2_d),
        .reg_access_o (reg_access),
        .claim_i      (claim),
        .claim_rd_i   (claim_rd),
        .wb_en_i      (wb_en),
        .wb_rd_i      (wb_rd_o),
        .wb_d_i       (wb_d)
    );

    rv_execute rv_execute_i (
        .clk          (clk),
        .resetn_i     (resetn_i),
        .ex_give_i    (ex_give),
        .ex_get_o     (ex_get),
        .ex_alu_op_i  (ex_alu_op),
        .ex_mem_op_i  (ex_mem_op),
        .ex_rd_i      (ex_rd),
        .ex_wen_i     (ex_wen),
        .ex_a_i       (ex_a),
        .ex_b_i       (ex_b),
        .ex_store_d_i (ex_store_d),
        .wb_en_o      (wb_en),
        .wb_rd_o      (wb_rd_o),
        .wb_d_o       (wb_d),
        .wb_valid_o   (wb_valid_o),
        .wb_data_o    (wb_data_o),
        .wb_ready_i   (wb_ready_i)
    );

endmodule

// ==== dv/rv_core_assertions.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core_assertions (
    input logic                               clk,
    input logic                               resetn_i,
    input logic                               instr_give_i,
    input logic                               instr_get_i,
    input logic [31:0]                        instr_i,
    input logic                               inv_instr_i,
    input logic                               wb_valid_i,
    input logic [`RV_XLEN-1:0]                wb_data_i,
    input logic [$clog2(`RV_NREGS)-1:0]       wb_rd_i,
    input logic                               wb_ready_i,
    input logic                               ex_give_i,
    input logic [$clog2(`RV_NREGS)-1:0]       rs1_addr_i,
    input logic [$clog2(`RV_NREGS)-1:0]       rs2_addr_i
);
    int unsigned assert_fails = 0;

    // Offered word stays put until decode takes it
    give_held_a: assert property (@(posedge clk) disable iff (resetn_i)
        instr_give_i && !instr_get_i |=> instr_give_i && $stable(instr_i))
        else begin
            assert_fails++;
            $error("instruction offer dropped or changed before transfer");
        end

    wb_stable_a: assert property (@(posedge clk) disable iff (resetn_i)
        wb_valid_i && !wb_ready_i |=> wb_valid_i && $stable(wb_data_i))
        else begin
            assert_fails++;
            $error("writeback dropped or changed while stalled");
        end

    // Scoreboard must hold issue while a source still waits for its writeback
    issue_access_a: assert property (@(posedge clk) disable iff (resetn_i)
        ex_give_i && wb_valid_i && wb_rd_i != '0 |->
            rs1_addr_i != wb_rd_i && rs2_addr_i != wb_rd_i)
        else begin
            assert_fails++;
            $error("issue to execute while an operand has a writeback pending");
        end

    inv_pulse_a: assert property (@(posedge clk) disable iff (resetn_i)
        inv_instr_i |=> !inv_instr_i)
        else begin
            assert_fails++;
            $error("invalid-instruction flag high for two cycles");
        end

endmodule

bind rv_core_top rv_core_assertions rv_core_assertions_i (
    .clk          (clk),
    .resetn_i     (resetn_i),
    .instr_give_i (instr_give_i),
    .instr_get_i  (instr_get_o),
    .instr_i      (instr_i),
    .inv_instr_i  (inv_instr_o),
    .wb_valid_i   (wb_valid_o),
    .wb_data_i    (wb_data_o),
    .wb_rd_i      (wb_rd_o),
    .wb_ready_i   (wb_ready_i),
    .ex_give_i    (ex_give),
    .rs1_addr_i   (rs1_addr),
    .rs2_addr_i   (rs2_addr)
);

// ==== dv/rv_core_tb.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core_tb;
    import rv_isa_pkg::*;

    localparam int num_tests = 5;
    localparam int test_ns   = 2000;

    logic                          clk;
    logic                          resetn_i;
    logic                          instr_give_i;
    logic                          instr_get_o;
    logic [31:0]                   instr_i;
    logic                          inv_instr_o;
    logic                          wb_valid_o;
    logic [$clog2(`RV_NREGS)-1:0]  wb_rd_o;
    logic [`RV_XLEN-1:0]           wb_data_o;
    logic                          wb_ready_i;

    // Reference state and expected writebacks in program order
    logic [31:0] model_regs [`RV_NREGS];
    logic [31:0] model_mem [`RV_DMEM_WORDS];
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_data_q [$];
    logic [31:0] prog [$];

    int unsigned errors;
    int unsigned tests_passed;
    int unsigned wb_seen;
    int unsigned wb_expected;
    int unsigned inv_seen;
    int unsigned inv_expected;
    bit          random_ready;
    bit          stream_done;

    rv_core_top rv_core_top_i (
        .clk          (clk),
        .resetn_i     (resetn_i),
        .instr_give_i (instr_give_i),
        .instr_get_o  (instr_get_o),
        .instr_i      (instr_i),
        .inv_instr_o  (inv_instr_o),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o),
        .wb_ready_i   (wb_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(num_tests * test_ns);
        $display("Timeout: run did not finish within %0d ns", num_tests * test_ns);
        $display("TEST FAILED");
        $finish;
    end

    // Counts accepted writebacks and invalid pulses
    always @(posedge clk) begin
        if (!resetn_i) begin
            if (wb_valid_o && wb_ready_i) begin
                wb_seen++;
                if (wb_seen > wb_expected) begin
                    $display("ERROR: writeback to x%0d with no instruction pending", wb_rd_o);
                    errors++;
                end
            end
            if (inv_instr_o) begin
                inv_seen++;
                if (inv_seen > inv_expected) begin
                    $display("ERROR: invalid-instruction pulse on a valid instruction");
                    errors++;
                end
            end
        end
    end

    function automatic logic [11:0] rnd12();
        logic [31:0] r;
        r = $urandom;
        return r[11:0];
    endfunction

    function automatic logic [19:0] rnd20();
        logic [31:0] r;
        r = $urandom;
        return r[19:0];
    endfunction

    function automatic logic [2:0] pick_f3();
        case ($urandom_range(4, 0))
            0:       return F3_ADD;
            1:       return F3_SLT;
            2:       return F3_XOR;
            3:       return F3_OR;
            default: return F3_AND;
        endcase
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [11:0] imm,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_sw(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, F3_LW, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic bit alu_ref(input logic [2:0] f3, input logic [31:0] a,
                                   input logic [31:0] b, output logic [31:0] res);
        alu_ref = 1'b1;
        res = '0;
        case (f3)
            F3_ADD:  res = a + b;
            F3_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_XOR:  res = a ^ b;
            F3_OR:   res = a | b;
            F3_AND:  res = a & b;
            default: alu_ref = 1'b0;
        endcase
    endfunction

    // ISA semantics of one word, applied in program order
    task automatic model_instr(input logic [31:0] w);
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] addr;
        logic [31:0] res;
        bit          ok;
        rd = w[11:7];
        f3 = w[14:12];
        a = model_regs[w[19:15]];
        b = model_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        res = '0;
        ok = 1'b1;
        case (w[6:0])
            OPC_LUI:    res = {w[31:12], 12'h000};
            OPC_OP_IMM: ok = alu_ref(f3, a, imm_i, res);
            OPC_OP: begin
                if (w[31:25] == 7'b0) begin
                    ok = alu_ref(f3, a, b, res);
                end else if (w[31:25] == F7_SUB && f3 == F3_ADD) begin
                    res = a - b;
                end else begin
                    ok = 1'b0;
                end
            end
            OPC_LOAD: begin
                ok = (f3 == F3_LW);
                addr = a + imm_i;
                res = model_mem[addr[5:2]];
            end
            OPC_STORE: begin
                ok = (f3 == F3_LW);
                addr = a + imm_s;
                if (ok) begin
                    model_mem[addr[5:2]] = b;
                end
            end
            default: ok = 1'b0;
        endcase
        if (!ok) begin
            inv_expected++;
        end else if (w[6:0] != OPC_STORE) begin
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(res);
            wb_expected++;
            if (rd != 5'd0) begin
                model_regs[rd] = res;
            end
        end
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %08h, expected %08h", name, got, exp);
            errors++;
        end
    endtask

    // Called on a falling edge; returns on the falling edge after the transfer
    task automatic send_instr(input logic [31:0] word);
        instr_give_i = 1'b1;
        instr_i = word;
        do begin
            @(posedge clk);
        end while (!instr_get_o);
        @(negedge clk);
        instr_give_i = 1'b0;
    endtask

    task automatic expect_wb(input logic [4:0] rd, input logic [31:0] data);
        do begin
            @(posedge clk);
        end while (!(wb_valid_o && wb_ready_i));
        check("wb_rd_o", wb_rd_o, rd);
        check("wb_data_o", wb_data_o, data);
        @(negedge clk);
    endtask

    task automatic run_program();
        foreach (prog[i]) begin
            model_instr(prog[i]);
        end
        stream_done = 1'b0;
        fork
            begin
                foreach (prog[i]) begin
                    send_instr(prog[i]);
                end
            end
            begin
                while (exp_rd_q.size() > 0) begin
                    expect_wb(exp_rd_q.pop_front(), exp_data_q.pop_front());
                end
                stream_done = 1'b1;
            end
            begin
                while (!stream_done) begin
                    @(negedge clk);
                    wb_ready_i = random_ready ? 1'($urandom_range(1, 0)) : 1'b1;
                end
                wb_ready_i = 1'b1;
            end
        join
        prog.delete();
    endtask

    task automatic report_test(input string name, input int unsigned err_before);
        if (errors == err_before) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - err_before);
        end
    endtask

    task automatic test_lui_op_imm();
        int unsigned e0;
        e0 = errors;
        prog.push_back(enc_lui(rnd20(), 5'd1));
        prog.push_back(enc_i(OPC_OP_IMM, rnd12(), 5'd0, F3_ADD, 5'd2));
        prog.push_back(enc_i(OPC_OP_IMM, 12'h800 | rnd12(), 5'd1, F3_ADD, 5'd3));
        prog.push_back(enc_i(OPC_OP_IMM, rnd12(), 5'd3, F3_SLT, 5'd4));
        prog.push_back(enc_i(OPC_OP_IMM, 12'hfff, 5'd0, F3_SLT, 5'd5));
        prog.push_back(enc_i(OPC_OP_IMM, 12'h001, 5'd0, F3_SLT, 5'd6));
        prog.push_back(enc_i(OPC_OP_IMM, 12'h800 | rnd12(), 5'd1, F3_XOR, 5'd7));
        prog.push_back(enc_i(OPC_OP_IMM, rnd12(), 5'd2, F3_OR, 5'd8));
        prog.push_back(enc_i(OPC_OP_IMM, 12'h800 | rnd12(), 5'd1, F3_AND, 5'd9));
        run_program();
        report_test("lui_op_imm", e0);
    endtask

    task automatic test_op_chain();
        int unsigned e0;
        e0 = errors;
        prog.push_back(enc_lui(rnd20(), 5'd10));
        prog.push_back(enc_i(OPC_OP_IMM, rnd12(), 5'd10, F3_ADD, 5'd10));
        prog.push_back(enc_lui(rnd20(), 5'd11));
        prog.push_back(enc_i(OPC_OP_IMM, rnd12(), 5'd11, F3_ADD, 5'd11));
        // Each step reads the result just produced
        prog.push_back(enc_r(7'b0, 5'd11, 5'd10, F3_ADD, 5'd12));
        prog.push_back(enc_r(F7_SUB, 5'd10, 5'd12, F3_ADD, 5'd13));
        prog.push_back(enc_r(7'b0, 5'd12, 5'd13, F3_SLT, 5'd14));
        prog.push_back(enc_r(7'b0, 5'd13, 5'd14, F3_XOR, 5'd15));
        prog.push_back(enc_r(7'b0, 5'd10, 5'd15, F3_OR, 5'd16));
        prog.push_back(enc_r(7'b0, 5'd11, 5'd16, F3_AND, 5'd17));
        prog.push_back(enc_r(7'b0, 5'd11, 5'd10, F3_ADD, 5'd0));
        prog.push_back(enc_r(7'b0, 5'd10, 5'd0, F3_OR, 5'd18));
        prog.push_back(enc_r(7'b0, 5'd0, 5'd0, F3_ADD, 5'd19));
        run_program();
        report_test("op_chain", e0);
    endtask

    task automatic test_store_load();
        int unsigned e0;
        int unsigned w0;
        int unsigned skip;
        int unsigned idx;
        e0 = errors;
        w0 = wb_seen;
        skip = $urandom_range(15, 0);
        for (int i = 0; i < 16; i++) begin
            do begin
                idx = $urandom_range(15, 0);
            end while (idx == skip);
            prog.push_back(enc_lui(rnd20(), 5'd20));
            prog.push_back(enc_i(OPC_OP_IMM, rnd12(), 5'd20, F3_XOR, 5'd20));
            prog.push_back(enc_sw(12'(idx * 4), 5'd20, 5'd0));
            prog.push_back(enc_i(OPC_LOAD, 12'(idx * 4), 5'd0, F3_LW, 5'd21));
        end
        // This word was never stored
        prog.push_back(enc_i(OPC_LOAD, 12'(skip * 4), 5'd0, F3_LW, 5'd22));
        run_program();
        check("writeback count", wb_seen - w0, 16 * 3 + 1);
        report_test("store_load", e0);
    endtask

    task automatic test_invalid();
        int unsigned e0;
        int unsigned w0;
        int unsigned i0;
        e0 = errors;
        w0 = wb_seen;
        i0 = inv_seen;
        prog.push_back({rnd20(), 5'd3, 7'b1111111});
        prog.push_back(enc_i(OPC_OP_IMM, rnd12(), 5'd0, F3_ADD, 5'd24));
        prog.push_back(enc_r(7'b0000001, 5'd10, 5'd11, F3_ADD, 5'd25));
        prog.push_back(enc_r(7'b0, 5'd10, 5'd11, F3_ADD, 5'd26));
        run_program();
        check("inv_instr_o pulses", inv_seen - i0, 2);
        check("writeback count", wb_seen - w0, 2);
        report_test("invalid", e0);
    endtask

    task automatic test_backpressure();
        int unsigned e0;
        int unsigned w0;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [3:0]  idx;
        e0 = errors;
        w0 = wb_seen;
        for (int i = 0; i < 20; i++) begin
            rd = 5'($urandom_range(7, 1));
            rs1 = 5'($urandom_range(7, 0));
            rs2 = 5'($urandom_range(7, 0));
            idx = 4'($urandom_range(15, 0));
            case ($urandom_range(4, 0))
                0:       prog.push_back(enc_lui(rnd20(), rd));
                1:       prog.push_back(enc_i(OPC_OP_IMM, rnd12(), rs1, pick_f3(), rd));
                2:       prog.push_back(enc_r(7'b0, rs2, rs1, pick_f3(), rd));
                3:       prog.push_back(enc_r(F7_SUB, rs2, rs1, F3_ADD, rd));
                default: prog.push_back(enc_i(OPC_LOAD, {6'b0, idx, 2'b00}, 5'd0, F3_LW, rd));
            endcase
        end
        random_ready = 1'b1;
        run_program();
        random_ready = 1'b0;
        check("writeback count", wb_seen - w0, 20);
        report_test("backpressure", e0);
    endtask

    initial begin
        void'($urandom(32'h5e28_4610));
        resetn_i = 1'b1;
        instr_give_i = 1'b0;
        instr_i = '0;
        wb_ready_i = 1'b1;
        errors = 0;
        tests_passed = 0;
        wb_seen = 0;
        wb_expected = 0;
        inv_seen = 0;
        inv_expected = 0;
        random_ready = 1'b0;
        stream_done = 1'b0;
        for (int i = 0; i < `RV_NREGS; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        resetn_i = 1'b0;

        test_lui_op_imm();
        test_op_chain();
        test_store_load();
        test_invalid();
        test_backpressure();

        errors += rv_core_top_i.rv_core_assertions_i.assert_fails;
        $display("%0d of %0d tests passed, %0d errors", tests_passed, num_tests, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== rv_decode.f ====
+incdir+include
src/rv_isa_pkg.sv
src/rv_pipe_pkg.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_core_top.sv
dv/rv_core_assertions.sv
dv/rv_core_tb.sv
